/* game_fsm.sv */
`default_nettype none

module game_fsm (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic             restart_i,
    input  wire logic             start_i,
    input  wire logic             all_collected_i,
    output game_pkg::game_state_t state_o
);

    game_pkg::game_state_t next_state;

    always_comb begin
        next_state = state_o;
        if (restart_i) begin
            next_state = game_pkg::GAME_TITLE;
        end else begin
            case (state_o)
                game_pkg::GAME_TITLE: begin
                    // any movement key starts the game
                    if (start_i) begin
                        next_state = game_pkg::GAME_PLAY;
                    end
                end
                game_pkg::GAME_PLAY: begin
                    if (all_collected_i) begin
                        next_state = game_pkg::GAME_WIN;
                    end
                end
                // win holds until restart
                default: next_state = state_o;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_o <= game_pkg::GAME_TITLE;
        end else begin
            state_o <= next_state;
        end
    end

endmodule

`default_nettype wire

/* game_pkg.sv */
`default_nettype none

package game_pkg;

    // pixel coordinates on the 640x480 screen
    typedef logic [9:0] xpos_t;
    typedef logic [8:0] ypos_t;

    // vertical speed, negative is upwards
    typedef logic signed [8:0] speed_t;

    typedef logic [7:0] scan_t;

    // number of snowflakes taken
    typedef logic [3:0] score_t;

    typedef enum logic [1:0] {
        GAME_TITLE = 2'b00,
        GAME_PLAY  = 2'b01,
        GAME_WIN   = 2'b11
    } game_state_t;

endpackage

`default_nettype wire

/* game_settings.svh */
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// clock cycles per movement tick standing in for 1 ms
`define TICK_CYCLES 16

// sprite and tile sizes in pixels
`define PLAYER_W 47
`define PLAYER_H 41
`define BLOCK_W 28
`define BLOCK_H 42
`define SNOW_W 24
`define SNOW_H 26

// map layout
`define FLOOR_BLOCKS 20
`define FLOOR_Y 374
`define FLOOR_PITCH 25
`define LEDGE_BLOCKS 10
`define LEDGE_Y 300
`define SNOW_COUNT 15
`define SNOW_X 144
`define SNOW_PITCH 26
`define START_X 250
`define START_Y 334

// physics in pixels per tick
`define WALK_STEP 2
`define JUMP_SPEED (-7)
`define GRAVITY 1
`define MAX_FALL 8

// ps/2 scan codes
`define KEY_UP 8'h1D
`define KEY_LEFT 8'h1C
`define KEY_DOWN 8'h1B
`define KEY_RIGHT 8'h23
`define KEY_RESTART 8'h2D

`endif

/* game_top.sv */
`default_nettype none

module game_top (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire game_pkg::scan_t  key_code_i,
    input  wire logic             key_valid_i,
    output logic                  key_ack_o,
    output game_pkg::game_state_t state_o,
    output game_pkg::score_t      score_o,
    output logic [5:0]            iced_o,
    output game_pkg::xpos_t       player_x_o,
    output game_pkg::ypos_t       player_y_o
);

    player_if body ();

    logic up;
    logic left;
    logic right;
    logic restart;
    logic start;
    logic all_collected;

    key_decoder u_keys (
        .clk        (clk),
        .reset_i    (reset_i),
        .key_code_i (key_code_i),
        .key_valid_i(key_valid_i),
        .key_ack_o  (key_ack_o),
        .up_o       (up),
        .left_o     (left),
        .right_o    (right),
        .restart_o  (restart)
    );

    player_motion u_motion (
        .clk      (clk),
        .reset_i  (reset_i),
        .up_i     (up),
        .left_i   (left),
        .right_i  (right),
        .state_i  (state_o),
        .restart_i(restart),
        .body     (body.mover)
    );

    ground_map u_ground (
        .clk      (clk),
        .reset_i  (reset_i),
        .restart_i(restart),
        .state_i  (state_o),
        .body     (body.sensor),
        .iced_o   (iced_o)
    );

    snow_collector u_snow (
        .clk            (clk),
        .reset_i        (reset_i),
        .restart_i      (restart),
        .state_i        (state_o),
        .body           (body.viewer),
        .score_o        (score_o),
        .all_collected_o(all_collected)
    );

    // any held movement key leaves the title screen
    assign start = up | left | right;

    game_fsm u_fsm (
        .clk            (clk),
        .reset_i        (reset_i),
        .restart_i      (restart),
        .start_i        (start),
        .all_collected_i(all_collected),
        .state_o        (state_o)
    );

    assign player_x_o = body.x;
    assign player_y_o = body.y;

endmodule

`default_nettype wire

/* ground_map.sv */
`default_nettype none

`include "game_settings.svh"

module ground_map (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  restart_i,
    input  wire game_pkg::game_state_t state_i,
    player_if.sensor                   body,
    output logic [5:0]                 iced_o
);

    localparam int NUM_BLOCKS = `FLOOR_BLOCKS + `LEDGE_BLOCKS;

    // player box edges one bit wider so the sums do not wrap
    logic [10:0] p_left;
    logic [10:0] p_right;
    logic [10:0] p_top;
    logic [10:0] p_bottom;

    logic [NUM_BLOCKS-1:0] ground_v;
    logic [NUM_BLOCKS-1:0] ceil_v;
    logic [NUM_BLOCKS-1:0] left_v;
    logic [NUM_BLOCKS-1:0] right_v;
    logic [NUM_BLOCKS-1:0] iced;

    assign p_left   = 11'(body.x);
    assign p_right  = 11'(body.x) + 11'(`PLAYER_W);
    assign p_top    = 11'(body.y);
    assign p_bottom = 11'(body.y) + 11'(`PLAYER_H);

    // floor row first, then the ledge row
    for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_block
        localparam logic [10:0] BX = (b < `FLOOR_BLOCKS) ? 11'(b * `FLOOR_PITCH)
                                                         : 11'((b - `FLOOR_BLOCKS) * `BLOCK_W);
        localparam logic [10:0] BY = (b < `FLOOR_BLOCKS) ? 11'(`FLOOR_Y) : 11'(`LEDGE_Y);
        localparam logic [10:0] BX_R = BX + 11'(`BLOCK_W);
        localparam logic [10:0] BY_B = BY + 11'(`BLOCK_H);

        logic x_ovl;
        logic y_ovl;

        assign x_ovl = (p_left < BX_R) && (BX < p_right);
        assign y_ovl = (p_top < BY_B) && (BY < p_bottom);

        assign ground_v[b] = (p_bottom == BY) && x_ovl;
        assign ceil_v[b]   = (p_top == BY_B) && x_ovl;
        assign right_v[b]  = (p_right == BX) && y_ovl;
        assign left_v[b]   = (p_left == BX_R) && y_ovl;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            body.on_ground   <= 1'b0;
            body.hit_ceiling <= 1'b0;
            body.hit_left    <= 1'b0;
            body.hit_right   <= 1'b0;
        end else begin
            body.on_ground   <= |ground_v;
            body.hit_ceiling <= |ceil_v;
            body.hit_left    <= |left_v;
            body.hit_right   <= |right_v;
        end
    end

    // blocks stood on during play stay iced
    always_ff @(posedge clk) begin
        if (reset_i || restart_i) begin
            iced <= '0;
        end else if (state_i == game_pkg::GAME_PLAY) begin
            iced <= iced | ground_v;
        end
    end

    always_comb begin
        iced_o = '0;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            iced_o = iced_o + 6'(iced[i]);
        end
    end

endmodule

`default_nettype wire

/* key_decoder.sv */
`default_nettype none

`include "game_settings.svh"

module key_decoder (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire game_pkg::scan_t key_code_i,
    input  wire logic            key_valid_i,
    output logic                 key_ack_o,
    output logic                 up_o,
    output logic                 left_o,
    output logic                 right_o,
    output logic                 restart_o
);

    logic accept;

    // a code still held while its ack is out was already taken
    assign accept = key_valid_i && !key_ack_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            key_ack_o <= 1'b0;
            up_o      <= 1'b0;
            left_o    <= 1'b0;
            right_o   <= 1'b0;
            restart_o <= 1'b0;
        end else begin
            key_ack_o <= accept;
            restart_o <= accept && (key_code_i == `KEY_RESTART);
            if (accept) begin
                // the latest code wins and any other code lets go of all keys
                up_o    <= (key_code_i == `KEY_UP);
                left_o  <= (key_code_i == `KEY_LEFT);
                right_o <= (key_code_i == `KEY_RIGHT);
            end
        end
    end

endmodule

`default_nettype wire

/* player_if.sv */
`default_nettype none

interface player_if;

    // top left corner of the player box
    game_pkg::xpos_t x;
    game_pkg::ypos_t y;

    // contacts against the ground blocks
    logic on_ground;
    logic hit_ceiling;
    logic hit_left;
    logic hit_right;

    modport mover (
        output x, y,
        input  on_ground, hit_ceiling, hit_left, hit_right
    );

    modport sensor (
        input  x, y,
        output on_ground, hit_ceiling, hit_left, hit_right
    );

    modport viewer (
        input x, y
    );

endinterface

`default_nettype wire

/* player_motion.sv */
`default_nettype none

`include "game_settings.svh"

module player_motion (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  up_i,
    input  wire logic                  left_i,
    input  wire logic                  right_i,
    input  wire game_pkg::game_state_t state_i,
    input  wire logic                  restart_i,
    player_if.mover                    body
);

    localparam int TICK_W = $clog2(`TICK_CYCLES);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick_q;
    game_pkg::speed_t  speed;
    game_pkg::speed_t  next_speed;
    game_pkg::xpos_t   next_x;

    // movement tick that only runs during play
    always_ff @(posedge clk) begin
        if (reset_i || state_i != game_pkg::GAME_PLAY) begin
            tick_cnt <= '0;
            tick_q   <= 1'b0;
        end else begin
            tick_q <= (tick_cnt == TICK_W'(`TICK_CYCLES - 1));
            if (tick_cnt == TICK_W'(`TICK_CYCLES - 1)) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // right beats left when both are held
    always_comb begin
        if (right_i) begin
            next_x = body.x + game_pkg::xpos_t'(`WALK_STEP);
        end else if (left_i) begin
            next_x = body.x - game_pkg::xpos_t'(`WALK_STEP);
        end else begin
            next_x = body.x;
        end
    end

    always_comb begin
        if (body.hit_ceiling) begin
            next_speed = game_pkg::speed_t'(1);
        end else if (up_i && body.on_ground) begin
            next_speed = game_pkg::speed_t'(`JUMP_SPEED);
        end else if (body.on_ground && speed >= game_pkg::speed_t'(0)) begin
            next_speed = '0;
        end else if (speed >= game_pkg::speed_t'(`MAX_FALL - `GRAVITY)) begin
            // terminal fall speed
            next_speed = game_pkg::speed_t'(`MAX_FALL);
        end else begin
            next_speed = speed + game_pkg::speed_t'(`GRAVITY);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || restart_i) begin
            body.x <= game_pkg::xpos_t'(`START_X);
            body.y <= game_pkg::ypos_t'(`START_Y);
            speed  <= '0;
        end else if (tick_q) begin
            body.x <= next_x;
            // y moves by the old speed before it is updated
            body.y <= body.y + game_pkg::ypos_t'(speed);
            speed  <= next_speed;
        end
    end

endmodule

`default_nettype wire

/* snow_collector.sv */
`default_nettype none

`include "game_settings.svh"

module snow_collector (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  restart_i,
    input  wire game_pkg::game_state_t state_i,
    player_if.viewer                   body,
    output game_pkg::score_t           score_o,
    output logic                       all_collected_o
);

    logic [10:0] p_left;
    logic [10:0] p_right;
    logic [10:0] p_top;
    logic [10:0] p_bottom;

    logic [`SNOW_COUNT-1:0] overlap;
    logic [`SNOW_COUNT-1:0] fresh;
    logic [`SNOW_COUNT-1:0] taken;
    game_pkg::score_t       fresh_cnt;

    assign p_left   = 11'(body.x);
    assign p_right  = 11'(body.x) + 11'(`PLAYER_W);
    assign p_top    = 11'(body.y);
    assign p_bottom = 11'(body.y) + 11'(`PLAYER_H);

    // flakes hang in one column, one pitch apart
    for (genvar s = 0; s < `SNOW_COUNT; s++) begin : g_flake
        localparam logic [10:0] SX = 11'(`SNOW_X);
        localparam logic [10:0] SY = 11'(s * `SNOW_PITCH);

        assign overlap[s] = (p_left < SX + 11'(`SNOW_W)) && (SX < p_right)
                         && (p_top < SY + 11'(`SNOW_H)) && (SY < p_bottom);
    end

    assign fresh = (state_i == game_pkg::GAME_PLAY) ? (overlap & ~taken) : '0;

    // the player box can cover more than one flake at a time
    always_comb begin
        fresh_cnt = '0;
        for (int i = 0; i < `SNOW_COUNT; i++) begin
            fresh_cnt = fresh_cnt + game_pkg::score_t'(fresh[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || restart_i) begin
            taken   <= '0;
            score_o <= '0;
        end else begin
            taken   <= taken | fresh;
            score_o <= score_o + fresh_cnt;
        end
    end

    assign all_collected_o = &taken;

endmodule

`default_nettype wire

/* tb_game.sv */
`default_nettype none

`include "game_settings.svh"

module tb_game;

    localparam int NUM_BLOCKS = `FLOOR_BLOCKS + `LEDGE_BLOCKS;
    localparam int ACK_LIMIT  = 20;
    localparam int TICK_LIMIT = 4 * `TICK_CYCLES;

    logic                  clk;
    logic                  reset;
    game_pkg::scan_t       key_code;
    logic                  key_valid;
    logic                  key_ack;
    game_pkg::game_state_t state;
    game_pkg::score_t      score;
    logic [5:0]            iced;
    game_pkg::xpos_t       player_x;
    game_pkg::ypos_t       player_y;

    // reference model of the game
    int                    m_x;
    int                    m_y;
    int                    m_speed;
    int                    m_score;
    bit                    m_up;
    bit                    m_left;
    bit                    m_right;
    bit [NUM_BLOCKS-1:0]   m_iced;
    bit [`SNOW_COUNT-1:0]  m_taken;
    game_pkg::game_state_t m_state;

    // mirror of the movement tick used for timing
    int                    m_cnt;
    bit                    m_tick;

    logic [31:0]           lfsr_q = 32'hcea5_f950;
    int                    checks;
    int                    errors;

    game_top UUT (
        .clk        (clk),
        .reset_i    (reset),
        .key_code_i (key_code),
        .key_valid_i(key_valid),
        .key_ack_o  (key_ack),
        .state_o    (state),
        .score_o    (score),
        .iced_o     (iced),
        .player_x_o (player_x),
        .player_y_o (player_y)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset || state != game_pkg::GAME_PLAY) begin
            m_cnt  = 0;
            m_tick = 1'b0;
        end else begin
            m_tick = (m_cnt == `TICK_CYCLES - 1);
            m_cnt  = (m_cnt == `TICK_CYCLES - 1) ? 0 : m_cnt + 1;
        end
    end

    // galois lfsr stepped once per bit
    function automatic int rand_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value  = (value << 1) | int'(lfsr_q[0]);
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    function automatic int block_x(input int b);
        if (b < `FLOOR_BLOCKS) begin
            return b * `FLOOR_PITCH;
        end
        return (b - `FLOOR_BLOCKS) * `BLOCK_W;
    endfunction

    function automatic int block_y(input int b);
        return (b < `FLOOR_BLOCKS) ? `FLOOR_Y : `LEDGE_Y;
    endfunction

    function automatic bit x_overlap(input int px, input int ox, input int w);
        return (px < ox + w) && (ox < px + `PLAYER_W);
    endfunction

    function automatic bit stands_on(input int px, input int py, input int b);
        return (py + `PLAYER_H == block_y(b)) && x_overlap(px, block_x(b), `BLOCK_W);
    endfunction

    function automatic bit bumps_head(input int px, input int py, input int b);
        return (py == block_y(b) + `BLOCK_H) && x_overlap(px, block_x(b), `BLOCK_W);
    endfunction

    function automatic bit touches_flake(input int px, input int py, input int s);
        int fy;
        fy = s * `SNOW_PITCH;
        return x_overlap(px, `SNOW_X, `SNOW_W) && (py < fy + `SNOW_H) && (fy < py + `PLAYER_H);
    endfunction

    function automatic void reset_model();
        m_x     = `START_X;
        m_y     = `START_Y;
        m_speed = 0;
        m_score = 0;
        m_up    = 1'b0;
        m_left  = 1'b0;
        m_right = 1'b0;
        m_iced  = '0;
        m_taken = '0;
        m_state = game_pkg::GAME_TITLE;
    endfunction

    function automatic void model_key(input logic [7:0] code);
        m_up    = (code == `KEY_UP);
        m_left  = (code == `KEY_LEFT);
        m_right = (code == `KEY_RIGHT);
        if (code == `KEY_RESTART) begin
            reset_model();
        end else if (m_state == game_pkg::GAME_TITLE && (m_up || m_left || m_right)) begin
            m_state = game_pkg::GAME_PLAY;
        end
    endfunction

    // one movement tick of the game rules
    function automatic void model_tick();
        bit ground;
        bit ceiling;
        ground  = 1'b0;
        ceiling = 1'b0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            ground  |= stands_on(m_x, m_y, b);
            ceiling |= bumps_head(m_x, m_y, b);
        end
        if (m_right) begin
            m_x = (m_x + `WALK_STEP) % 1024;
        end else if (m_left) begin
            m_x = (m_x + 1024 - `WALK_STEP) % 1024;
        end
        m_y = ((m_y + m_speed) % 512 + 512) % 512;
        if (ceiling) begin
            m_speed = 1;
        end else if (m_up && ground) begin
            m_speed = `JUMP_SPEED;
        end else if (ground && m_speed >= 0) begin
            m_speed = 0;
        end else if (m_speed + `GRAVITY > `MAX_FALL) begin
            m_speed = `MAX_FALL;
        end else begin
            m_speed = m_speed + `GRAVITY;
        end
        // new position ices blocks and takes flakes
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            if (stands_on(m_x, m_y, b)) begin
                m_iced[b] = 1'b1;
            end
        end
        for (int s = 0; s < `SNOW_COUNT; s++) begin
            if (!m_taken[s] && touches_flake(m_x, m_y, s)) begin
                m_taken[s] = 1'b1;
                m_score++;
            end
        end
        if (&m_taken) begin
            m_state = game_pkg::GAME_WIN;
        end
    endfunction

    function automatic int iced_count();
        int n;
        n = 0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            n += int'(m_iced[b]);
        end
        return n;
    endfunction

    task automatic check_value(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("timeout: %s", reason);
        $display("Something failed");
        $finish;
    endtask

    task automatic check_outputs();
        check_value(int'(player_x), m_x, "player_x_o");
        check_value(int'(player_y), m_y, "player_y_o");
        check_value(int'(score), m_score, "score_o");
        check_value(int'(iced), iced_count(), "iced_o");
        check_value(int'(state), int'(m_state), "state_o");
    endtask

    // offer one code and expect a single ack pulse
    task automatic send_key(input logic [7:0] code);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        key_code  <= code;
        key_valid <= 1'b1;
        @(negedge clk);
        while (!key_ack) begin
            wait_cnt++;
            if (wait_cnt > ACK_LIMIT) begin
                abort_run("key_ack_o never rose for an offered scan code");
            end
            @(negedge clk);
        end
        @(posedge clk);
        key_valid <= 1'b0;
        @(negedge clk);
        check_value(int'(key_ack), 0, "key_ack_o one cycle after the pulse");
        @(negedge clk);
        check_value(int'(key_ack), 0, "key_ack_o two cycles after the pulse");
        model_key(code);
    endtask

    // wait for the next tick and compare once everything has settled
    task automatic tick_and_check();
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        while (!m_tick) begin
            wait_cnt++;
            if (wait_cnt > TICK_LIMIT) begin
                abort_run("no movement tick arrived during play");
            end
            @(negedge clk);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        model_tick();
        check_outputs();
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int             mark;
        int             pick;
        int             gap;
        int             steps;
        logic [7:0]     code;
        logic [7:0]     want;

        checks    = 0;
        errors    = 0;
        reset     = 1'b1;
        key_code  = '0;
        key_valid = 1'b0;
        reset_model();
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // 1 reset values and no motion on the title screen
        mark = errors;
        @(negedge clk);
        check_outputs();
        check_value(int'(key_ack), 0, "key_ack_o after reset");
        repeat (5 * `TICK_CYCLES) @(negedge clk);
        check_outputs();
        report_test("reset_and_title", mark);

        // 2 handshake where a non-movement key keeps the title
        mark = errors;
        send_key(`KEY_DOWN);
        check_value(int'(state), int'(m_state), "state_o after a non-movement key");
        send_key(`KEY_LEFT);
        check_value(int'(state), int'(game_pkg::GAME_PLAY), "state_o after a movement key");
        report_test("key_handshake", mark);

        // 3 random keys with gaps of whole ticks
        mark = errors;
        for (int i = 0; i < 40 && m_state == game_pkg::GAME_PLAY; i++) begin
            pick = rand_bits(2);
            case (pick)
                0: code = `KEY_LEFT;
                1: code = `KEY_RIGHT;
                2: code = `KEY_UP;
                default: code = `KEY_DOWN;
            endcase
            send_key(code);
            gap = rand_bits(2) + 1;
            for (int g = 0; g < gap && m_state == game_pkg::GAME_PLAY; g++) begin
                tick_and_check();
            end
        end
        report_test("random_motion", mark);

        // 4
        mark = errors;
        check_value(int'(iced), iced_count(), "iced_o after random play");
        report_test("iced_blocks", mark);

        // 5 steer under the snowflake column and let the fall sweep it
        mark = errors;
        steps = 0;
        while (m_state == game_pkg::GAME_PLAY && (m_x < 100 || m_x > 160) && steps < 600) begin
            want = (m_x > 130 && m_x < 600) ? `KEY_LEFT : `KEY_RIGHT;
            if ((want == `KEY_LEFT && !m_left) || (want == `KEY_RIGHT && !m_right)) begin
                send_key(want);
            end
            tick_and_check();
            steps++;
        end
        if (m_state == game_pkg::GAME_PLAY) begin
            send_key(`KEY_DOWN);
        end
        steps = 0;
        while (m_state == game_pkg::GAME_PLAY && steps < 200) begin
            tick_and_check();
            steps++;
        end
        if (m_state != game_pkg::GAME_WIN) begin
            errors++;
            $display("the game never reached the win state at time %0t", $time);
        end
        repeat (4 * `TICK_CYCLES) @(negedge clk);
        check_outputs();
        report_test("snowflakes_and_win", mark);

        // 6
        mark = errors;
        send_key(`KEY_RESTART);
        check_outputs();
        check_value(int'(player_x), `START_X, "player_x_o after restart");
        check_value(int'(player_y), `START_Y, "player_y_o after restart");
        report_test("restart", mark);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
game_pkg.sv
player_if.sv
key_decoder.sv
player_motion.sv
ground_map.sv
snow_collector.sv
game_fsm.sv
game_top.sv
tb_game.sv
